/* rtl/dcache_pkg.sv */
// ----------------------------------------------------------
// data cache geometry and field types
// 2 ways x 8 sets, two 32-bit words per block (8 bytes)
// addresses are byte addresses, always word aligned
// ----------------------------------------------------------

package dcache_pkg;

	typedef logic [31:0] word_t;
	typedef logic [25:0] tag_t;	// addr[31:6]
	typedef logic [2:0] idx_t;	// addr[5:3]
	typedef logic way_t;

	localparam int NUM_SETS = 8;
	localparam int NUM_WAYS = 2;
	localparam int FRAME_COUNT = NUM_SETS * NUM_WAYS;

	// hits minus misses land here on halt
	localparam word_t STATS_ADDR = 32'h0000_3100;

	// 92 bits: valid, dirty, tag, word 1, word 0
	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
		word_t word1;	// addr[2] set
		word_t word0;
	} frame_t;

endpackage

/* rtl/dcache_frames.sv */
// ----------------------------------------------------------
// frame store for the data cache
// lookup and both read paths are combinational
// reset clears only valid, dirty and the lru bits
// ----------------------------------------------------------

`timescale 1ns/1ns

module dcache_frames (
	input logic CLK,
	input logic nRST,
	input dcache_pkg::word_t lookup_addr,
	input dcache_pkg::way_t rd_way,
	input dcache_pkg::idx_t rd_index,
	input logic rd_word,
	input logic wr_en,
	input logic fill_en,
	input logic mark_dirty,
	input logic clean_en,
	input logic inval_en,
	input logic touch,
	input dcache_pkg::way_t wr_way,
	input dcache_pkg::idx_t wr_index,
	input logic wr_word,
	input dcache_pkg::word_t wr_data,
	input dcache_pkg::tag_t wr_tag,
	output logic hit,
	output dcache_pkg::way_t hit_way,
	output dcache_pkg::word_t hit_data,
	output dcache_pkg::way_t victim_way,
	output logic victim_dirty,
	output dcache_pkg::tag_t victim_tag,
	output dcache_pkg::tag_t rd_tag,
	output dcache_pkg::word_t rd_data,
	output logic rd_dirty
);

	dcache_pkg::frame_t frames [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];
	logic [dcache_pkg::NUM_SETS-1:0] lru;	// way to evict next, per set

	dcache_pkg::idx_t look_index;
	dcache_pkg::tag_t look_tag;
	dcache_pkg::frame_t set0, set1, hit_frame, victim_frame, rd_frame;
	logic hit0, hit1;

	assign look_index = lookup_addr[5:3];
	assign look_tag = lookup_addr[31:6];

	assign set0 = frames[0][look_index];
	assign set1 = frames[1][look_index];

	assign hit0 = set0.valid && (set0.tag == look_tag);
	assign hit1 = set1.valid && (set1.tag == look_tag);
	assign hit = hit0 || hit1;
	assign hit_way = dcache_pkg::way_t'(!hit0);

	assign hit_frame = hit0 ? set0 : set1;
	assign hit_data = lookup_addr[2] ? hit_frame.word1 : hit_frame.word0;

	// empty way first, way 0 preferred, else lru
	always_comb begin
		if (!set0.valid) begin
			victim_way = 1'b0;
		end else if (!set1.valid) begin
			victim_way = 1'b1;
		end else begin
			victim_way = lru[look_index];
		end
	end

	assign victim_frame = frames[victim_way][look_index];
	assign victim_dirty = victim_frame.valid && victim_frame.dirty;
	assign victim_tag = victim_frame.tag;

	assign rd_frame = frames[rd_way][rd_index];
	assign rd_tag = rd_frame.tag;
	assign rd_data = rd_word ? rd_frame.word1 : rd_frame.word0;
	assign rd_dirty = rd_frame.valid && rd_frame.dirty;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
				for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
					frames[w][s].valid <= 1'b0;
					frames[w][s].dirty <= 1'b0;
				end
			end
			lru <= '0;
		end else begin
			if (fill_en) begin	// new block, clean until marked
				frames[wr_way][wr_index].tag <= wr_tag;
				frames[wr_way][wr_index].valid <= 1'b1;
				frames[wr_way][wr_index].dirty <= 1'b0;
			end
			if (wr_en) begin
				if (wr_word) begin
					frames[wr_way][wr_index].word1 <= wr_data;
				end else begin
					frames[wr_way][wr_index].word0 <= wr_data;
				end
			end
			if (mark_dirty) begin
				frames[wr_way][wr_index].dirty <= 1'b1;
			end
			if (clean_en) begin
				frames[wr_way][wr_index].dirty <= 1'b0;
			end
			if (inval_en) begin
				frames[wr_way][wr_index].valid <= 1'b0;
				frames[wr_way][wr_index].dirty <= 1'b0;
			end
			if (touch) begin
				lru[wr_index] <= ~wr_way;
			end
		end
	end

endmodule

/* rtl/dcache_ctrl.sv */
// ----------------------------------------------------------
// data cache controller: miss handling, write-back, flush
// CPU must hold its request until dhit
// memory requests stay unchanged while dwait is high
// ----------------------------------------------------------

`timescale 1ns/1ns

module dcache_ctrl (
	input logic CLK,
	input logic nRST,
	input logic dmem_ren,
	input logic dmem_wen,
	input logic halt,
	input logic dwait,
	input dcache_pkg::word_t dmem_addr,
	input dcache_pkg::word_t dmem_store,
	input dcache_pkg::word_t dload,
	input logic hit,
	input dcache_pkg::way_t hit_way,
	input dcache_pkg::word_t hit_data,
	input dcache_pkg::way_t victim_way,
	input logic victim_dirty,
	input dcache_pkg::tag_t victim_tag,
	input dcache_pkg::tag_t rd_tag,
	input dcache_pkg::word_t rd_data,
	input logic rd_dirty,
	output dcache_pkg::word_t dmem_load,
	output logic dhit,
	output logic flushed,
	output logic dren,
	output logic dwen,
	output dcache_pkg::word_t daddr,
	output dcache_pkg::word_t dstore,
	output dcache_pkg::way_t rd_way,
	output dcache_pkg::idx_t rd_index,
	output logic rd_word,
	output logic wr_en,
	output logic fill_en,
	output logic mark_dirty,
	output logic clean_en,
	output logic inval_en,
	output logic touch,
	output dcache_pkg::way_t wr_way,
	output dcache_pkg::idx_t wr_index,
	output logic wr_word,
	output dcache_pkg::word_t wr_data,
	output dcache_pkg::tag_t wr_tag
);

	typedef enum logic [3:0] {
		IDLE, WB_WORD0, WB_WORD1, FILL_REQ, FILL_OTHER,
		FLUSH_SCAN, FLUSH_WORD1, STATS_WRITE, DONE
	} state_t;

	state_t state, next_state;
	dcache_pkg::way_t victim_q;
	dcache_pkg::word_t hit_cnt, miss_cnt;
	logic [$clog2(dcache_pkg::FRAME_COUNT)-1:0] flush_frame;
	logic hit_inc, miss_inc, frame_inc, last_frame;
	dcache_pkg::idx_t req_index, flush_index;
	logic req_word;
	dcache_pkg::way_t flush_way;

	assign req_index = dmem_addr[5:3];
	assign req_word = dmem_addr[2];
	assign flush_index = flush_frame[2:0];
	assign flush_way = flush_frame[3];
	assign last_frame = (int'(flush_frame) == dcache_pkg::FRAME_COUNT - 1);

	always_comb begin
		next_state = state;
		dhit = 1'b0;
		flushed = 1'b0;
		dmem_load = '0;
		dren = 1'b0;
		dwen = 1'b0;
		daddr = '0;
		dstore = '0;
		rd_way = victim_q;
		rd_index = req_index;
		rd_word = 1'b0;
		wr_en = 1'b0;
		fill_en = 1'b0;
		mark_dirty = 1'b0;
		clean_en = 1'b0;
		inval_en = 1'b0;
		touch = 1'b0;
		wr_way = victim_q;
		wr_index = req_index;
		wr_word = req_word;
		wr_data = dload;
		wr_tag = dmem_addr[31:6];
		hit_inc = 1'b0;
		miss_inc = 1'b0;
		frame_inc = 1'b0;

		case (state)
			IDLE: begin
				if (dmem_ren || dmem_wen) begin
					if (hit) begin
						dhit = 1'b1;
						dmem_load = hit_data;
						hit_inc = 1'b1;
						touch = 1'b1;
						wr_way = hit_way;
						if (dmem_wen) begin
							wr_en = 1'b1;
							wr_data = dmem_store;
							mark_dirty = 1'b1;
						end
					end else begin
						next_state = victim_dirty ? WB_WORD0 : FILL_REQ;
					end
				end else if (halt) begin
					next_state = FLUSH_SCAN;
				end
			end
			WB_WORD0, WB_WORD1: begin
				rd_word = (state == WB_WORD1);
				dwen = 1'b1;
				daddr = {victim_tag, req_index, rd_word, 2'b00};
				dstore = rd_data;
				if (!dwait) begin
					if (state == WB_WORD1) begin
						clean_en = 1'b1;	// memory copy now current
						next_state = FILL_REQ;
					end else begin
						next_state = WB_WORD1;
					end
				end
			end
			FILL_REQ: begin
				dren = 1'b1;
				daddr = dmem_addr;
				if (!dwait) begin
					fill_en = 1'b1;
					wr_en = 1'b1;
					wr_data = dmem_wen ? dmem_store : dload;	// merge store
					next_state = FILL_OTHER;
				end
			end
			FILL_OTHER: begin
				dren = 1'b1;
				daddr = {dmem_addr[31:3], ~req_word, 2'b00};
				dmem_load = hit_data;	// requested word already in place
				if (!dwait) begin
					wr_en = 1'b1;
					wr_word = ~req_word;
					mark_dirty = dmem_wen;
					touch = 1'b1;
					dhit = 1'b1;
					miss_inc = 1'b1;
					next_state = IDLE;
				end
			end
			FLUSH_SCAN, FLUSH_WORD1: begin
				rd_way = flush_way;
				rd_index = flush_index;
				rd_word = (state == FLUSH_WORD1);
				wr_way = flush_way;
				wr_index = flush_index;
				daddr = {rd_tag, flush_index, rd_word, 2'b00};
				dstore = rd_data;
				if (rd_dirty) begin
					dwen = 1'b1;
				end
				if (state == FLUSH_SCAN && rd_dirty) begin
					if (!dwait) begin
						next_state = FLUSH_WORD1;
					end
				end else if (state == FLUSH_SCAN || !dwait) begin
					inval_en = (state == FLUSH_WORD1);
					if (last_frame) begin
						next_state = STATS_WRITE;
					end else begin
						frame_inc = 1'b1;
						next_state = FLUSH_SCAN;
					end
				end
			end
			STATS_WRITE: begin
				dwen = 1'b1;
				daddr = dcache_pkg::STATS_ADDR;
				dstore = hit_cnt - miss_cnt;	// wraps mod 2^32
				if (!dwait) begin
					next_state = DONE;
				end
			end
			DONE: flushed = 1'b1;
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			victim_q <= 1'b0;
			hit_cnt <= '0;
			miss_cnt <= '0;
			flush_frame <= '0;
		end else begin
			state <= next_state;
			if (state == IDLE) begin
				victim_q <= victim_way;	// frozen once the miss starts
			end
			if (hit_inc) begin
				hit_cnt <= hit_cnt + 32'd1;
			end
			if (miss_inc) begin
				miss_cnt <= miss_cnt + 32'd1;
			end
			if (frame_inc) begin
				flush_frame <= flush_frame + 1'b1;
			end
		end
	end

endmodule

/* rtl/dcache.sv */
// ----------------------------------------------------------
// two-way write-back data cache, top level
// read and write hits complete in the request cycle
// flushed stays high after halt until reset
// ----------------------------------------------------------

`timescale 1ns/1ns

module dcache (
	input logic CLK,
	input logic nRST,
	input logic dmem_ren,
	input logic dmem_wen,
	input logic halt,
	input dcache_pkg::word_t dload,
	input logic dwait,
	input dcache_pkg::word_t dmem_addr,
	input dcache_pkg::word_t dmem_store,
	output dcache_pkg::word_t dmem_load,
	output logic dhit,
	output logic flushed,
	output logic dren,
	output logic dwen,
	output dcache_pkg::word_t daddr,
	output dcache_pkg::word_t dstore
);

	logic hit, victim_dirty, rd_dirty, rd_word, wr_word;
	logic wr_en, fill_en, mark_dirty, clean_en, inval_en, touch;
	dcache_pkg::way_t hit_way, victim_way, rd_way, wr_way;
	dcache_pkg::word_t hit_data, rd_data, wr_data;
	dcache_pkg::tag_t victim_tag, rd_tag, wr_tag;
	dcache_pkg::idx_t rd_index, wr_index;

	dcache_frames frames_i (
		.CLK, .nRST,
		.lookup_addr(dmem_addr),
		.rd_way, .rd_index, .rd_word,
		.wr_en, .fill_en, .mark_dirty, .clean_en, .inval_en, .touch,
		.wr_way, .wr_index, .wr_word, .wr_data, .wr_tag,
		.hit, .hit_way, .hit_data,
		.victim_way, .victim_dirty, .victim_tag,
		.rd_tag, .rd_data, .rd_dirty
	);

	dcache_ctrl ctrl_i (
		.CLK, .nRST,
		.dmem_ren, .dmem_wen, .halt, .dwait,
		.dmem_addr, .dmem_store, .dload,
		.hit, .hit_way, .hit_data,
		.victim_way, .victim_dirty, .victim_tag,
		.rd_tag, .rd_data, .rd_dirty,
		.dmem_load, .dhit, .flushed,
		.dren, .dwen, .daddr, .dstore,
		.rd_way, .rd_index, .rd_word,
		.wr_en, .fill_en, .mark_dirty, .clean_en, .inval_en, .touch,
		.wr_way, .wr_index, .wr_word, .wr_data, .wr_tag
	);

endmodule

/* tests/mem_model.sv */
// ----------------------------------------------------------
// word-addressed memory model, 4096 words (byte addr 13:2)
// reset fills each word from its own address
// each transfer waits 0 to 3 cycles with dwait high
// ----------------------------------------------------------

`timescale 1ns/1ns

module mem_model (
	input logic CLK,
	input logic nRST,
	input logic dren,
	input logic dwen,
	input dcache_pkg::word_t daddr,
	input dcache_pkg::word_t dstore,
	output dcache_pkg::word_t dload,
	output logic dwait
);

	dcache_pkg::word_t mem [0:4095];
	logic written [0:4095];	// set by any write, never cleared
	int write_count;
	logic [1:0] wait_left;
	logic req;
	logic [11:0] word_addr;

	function automatic dcache_pkg::word_t fill_word(input int index);
		dcache_pkg::word_t addr;
		addr = index * 4;
		return {~addr[15:0], addr[15:0]};
	endfunction

	assign req = dren || dwen;
	assign word_addr = daddr[13:2];
	assign dwait = req && (wait_left != 2'd0);
	assign dload = dren ? mem[word_addr] : '0;

	always @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < 4096; i++) begin
				mem[i] <= fill_word(i);
				written[i] <= 1'b0;
			end
			write_count <= 0;
			wait_left <= 2'd0;
		end else if (req) begin
			if (dwait) begin
				wait_left <= wait_left - 2'd1;
			end else begin
				wait_left <= 2'($urandom_range(3, 0));	// wait for the next transfer
				if (dwen) begin
					mem[word_addr] <= dstore;
					written[word_addr] <= 1'b1;
					write_count <= write_count + 1;
				end
			end
		end
	end

endmodule

/* tests/dcache_sva.sv */
// ----------------------------------------------------------
// memory port and flush checks, bound into dcache
// fail_count lets the testbench see a failed assertion
// ----------------------------------------------------------

`timescale 1ns/1ns

module dcache_sva (
	input logic CLK,
	input logic nRST,
	input logic dren,
	input logic dwen,
	input logic dwait,
	input dcache_pkg::word_t daddr,
	input dcache_pkg::word_t dstore,
	input logic flushed
);

	int fail_count = 0;

	one_direction: assert property (@(posedge CLK) disable iff (!nRST)
		!(dren && dwen))
		else begin
			fail_count++;
			$error("dren and dwen high together");
		end

	// a stalled request must not move
	hold_on_wait: assert property (@(posedge CLK) disable iff (!nRST)
		(dren || dwen) && dwait |=> $stable(dren) && $stable(dwen)
			&& $stable(daddr) && $stable(dstore))
		else begin
			fail_count++;
			$error("memory request changed while dwait was high");
		end

	flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
		flushed |=> flushed)
		else begin
			fail_count++;
			$error("flushed fell before reset");
		end

endmodule

/* tests/tb_dcache.sv */
// ----------------------------------------------------------
// directed tests for dcache against a random-wait memory
// the CPU side holds each request until dhit
// stops at the first mismatch or timeout
// ----------------------------------------------------------

`timescale 1ns/1ns

module tb_dcache;

	localparam int TIMEOUT = 200;	// cycles per wait

	logic CLK, nRST, dmem_ren, dmem_wen, halt, dwait, dhit, flushed, dren, dwen;
	dcache_pkg::word_t dmem_addr, dmem_store, dmem_load, dload, daddr, dstore;
	dcache_pkg::word_t shadow [dcache_pkg::word_t];	// values the CPU wrote
	int hits, misses;

	dcache dut_i (.*);
	mem_model mem_i (.CLK, .nRST, .dren, .dwen, .daddr, .dstore, .dload, .dwait);

	bind dcache dcache_sva sva_i (.*);

	always #5 CLK = ~CLK;

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compare_word(input string name, input dcache_pkg::word_t exp,
		input dcache_pkg::word_t act);
		if (exp !== act) begin
			stop_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			stop_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	function automatic dcache_pkg::word_t mem_word(input dcache_pkg::word_t addr);
		return mem_i.mem[addr[13:2]];
	endfunction

	function automatic dcache_pkg::word_t expect_read(input dcache_pkg::word_t addr);
		if (shadow.exists(addr)) begin
			return shadow[addr];
		end
		return mem_word(addr);
	endfunction

	// one CPU request, held until dhit; any dren before it marks a miss
	task automatic access(input string name, input logic wen, input dcache_pkg::word_t addr,
		input dcache_pkg::word_t data, output dcache_pkg::word_t load, output logic missed);
		int cycles;
		logic done;
		@(posedge CLK);
		dmem_ren <= !wen;
		dmem_wen <= wen;
		dmem_addr <= addr;
		dmem_store <= data;
		missed = 1'b0;
		done = 1'b0;
		cycles = 0;
		while (!done && cycles < TIMEOUT) begin
			@(negedge CLK);
			if (dren) missed = 1'b1;
			if (dhit) begin
				done = 1'b1;
				load = dmem_load;
			end
			cycles++;
		end
		if (!done) begin
			stop_run({"no dhit within the timeout in ", name});
		end else begin
			@(posedge CLK);
			dmem_ren <= 1'b0;
			dmem_wen <= 1'b0;
			if (missed) misses++;
			else hits++;
			if (wen) shadow[addr] = data;
		end
	endtask

	task automatic read_check(input string name, input dcache_pkg::word_t addr,
		input logic exp_miss);
		dcache_pkg::word_t exp, load;
		logic missed;
		exp = expect_read(addr);
		access(name, 1'b0, addr, '0, load, missed);
		compare_word(name, exp, load);
		compare_bit({name, " miss"}, exp_miss, missed);
	endtask

	task automatic write_check(input string name, input dcache_pkg::word_t addr,
		input dcache_pkg::word_t data, input logic exp_miss);
		dcache_pkg::word_t load;
		logic missed;
		access(name, 1'b1, addr, data, load, missed);
		compare_bit({name, " miss"}, exp_miss, missed);
	endtask

	task automatic test_miss_then_hit();
		read_check("miss_then_hit fill", 32'h48, 1'b1);	// set 1
		read_check("miss_then_hit other word", 32'h4C, 1'b0);
	endtask

	task automatic test_write_hit();
		dcache_pkg::word_t orig;
		orig = mem_word(32'h48);
		write_check("write_hit write", 32'h48, 32'hDEAD_BEEF, 1'b0);
		read_check("write_hit readback", 32'h48, 1'b0);
		compare_word("write_hit memory untouched", orig, mem_word(32'h48));
	endtask

	task automatic test_eviction();
		dcache_pkg::word_t orig14;
		int wc;
		orig14 = mem_word(32'h14);
		write_check("eviction dirty write", 32'h10, 32'hA11C_E000, 1'b1);	// set 2, way 0
		read_check("eviction second block", 32'h410, 1'b1);
		wc = mem_i.write_count;
		read_check("eviction third block", 32'h810, 1'b1);	// lru way 0 goes
		compare_word("eviction write count", dcache_pkg::word_t'(wc + 2),
			dcache_pkg::word_t'(mem_i.write_count));
		compare_word("eviction word 0", 32'hA11C_E000, mem_word(32'h10));
		compare_word("eviction word 1", orig14, mem_word(32'h14));
		compare_bit("eviction word 1 written", 1'b1, mem_i.written[32'h14 >> 2]);
		read_check("eviction reload", 32'h10, 1'b1);
	endtask

	task automatic test_write_miss();
		write_check("write_miss write", 32'h1C, 32'h0BAD_F00D, 1'b1);	// set 3, word 1
		read_check("write_miss other word", 32'h18, 1'b0);
		read_check("write_miss merged word", 32'h1C, 1'b0);
	endtask

	task automatic test_flush();
		int cycles;
		@(posedge CLK);
		halt <= 1'b1;
		cycles = 0;
		while (!flushed && cycles < TIMEOUT) begin
			@(negedge CLK);
			cycles++;
		end
		if (!flushed) begin
			stop_run("flushed did not rise within the timeout after halt");
		end else begin
			foreach (shadow[addr]) begin
				compare_word($sformatf("flush dirty word %h", addr), shadow[addr],
					mem_word(addr));
			end
			compare_word("flush stats", dcache_pkg::word_t'(hits - misses),
				mem_word(dcache_pkg::STATS_ADDR));
			repeat (5) begin
				@(negedge CLK);
				compare_bit("flush flushed held", 1'b1, flushed);
			end
		end
	endtask

	always @(negedge CLK) begin
		if (dut_i.sva_i.fail_count != 0) begin
			stop_run("a bound assertion on the memory port or flush failed");
		end
	end

	initial begin
		void'($urandom(61833));
		CLK = 1'b0;
		nRST = 1'b0;
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
		halt = 1'b0;
		dmem_addr = '0;
		dmem_store = '0;
		hits = 0;
		misses = 0;
		repeat (4) @(posedge CLK);
		nRST <= 1'b1;

		test_miss_then_hit();
		test_write_hit();
		test_eviction();
		test_write_miss();
		test_flush();

		@(negedge CLK);
		if (dut_i.sva_i.fail_count != 0) begin
			stop_run("a bound assertion failed before the end of the run");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

/* all.f */
rtl/dcache_pkg.sv
rtl/dcache_frames.sv
rtl/dcache_ctrl.sv
rtl/dcache.sv
tests/mem_model.sv
tests/dcache_sva.sv
tests/tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - files:
      - rtl/dcache_pkg.sv
      - rtl/dcache_frames.sv
      - rtl/dcache_ctrl.sv
      - rtl/dcache.sv
  - target: test
    files:
      - tests/mem_model.sv
      - tests/dcache_sva.sv
      - tests/tb_dcache.sv
